//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module fmSynth -f fmSynth.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_fmSynth -f fmSynth.f
	./obj_dir/Vtb_fmSynth | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir

//--- configBus.sv
`default_nettype none

interface configBus;

    // One-cycle write strobes, at most one high per cycle
    logic phaseStepWrite;
    logic noteOnWrite;
    logic levelWrite;
    logic tableWrite;

    // Valid only together with a strobe
    synthPipePkg::slotId_t slot;
    synthPipePkg::tableAddr_t tableAddr;
    synthRegPkg::regValue_t data;

    modport decoder (
        output phaseStepWrite, noteOnWrite, levelWrite, tableWrite,
        output slot, tableAddr, data
    );

    modport stage (
        input phaseStepWrite, noteOnWrite, levelWrite, tableWrite,
        input slot, tableAddr, data
    );

endinterface

`default_nettype wire

//--- fmSynth.f
+incdir+.
synthRegPkg.sv
synthPipePkg.sv
configBus.sv
spiSlave.sv
registerDecoder.sv
phaseAccumulator.sv
waveformGenerator.sv
operatorMixer.sv
fmSynth.sv
tb_fmSynth.sv

//--- fmSynth.sv
`default_nettype none

module fmSynth (
    input wire logic i_Clock,
    input wire logic i_rstN,
    input wire logic i_SpiCs,
    input wire logic i_SpiSck,
    input wire logic i_SpiMosi,
    output logic o_SpiMiso
);

    logic writeLevel;
    synthRegPkg::regNumber_u regNumber;
    synthRegPkg::regValue_t regValue;
    logic sampleReady;
    synthPipePkg::sample_t mixSample;

    // Pipeline between the stages
    synthPipePkg::slotId_t accSlot;
    logic accNoteOn;
    synthPipePkg::phase_t accPhase;
    synthPipePkg::slotId_t waveSlot;
    logic waveNoteOn;
    synthPipePkg::sample_t waveform;

    configBus configBus_inst ();

    spiSlave spiSlave_inst (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_SpiCs       (i_SpiCs),
        .i_SpiSck      (i_SpiSck),
        .i_SpiMosi     (i_SpiMosi),
        .o_SpiMiso     (o_SpiMiso),
        .i_SampleReady (sampleReady),
        .i_Sample      (mixSample),
        .o_WriteLevel  (writeLevel),
        .o_RegNumber   (regNumber),
        .o_RegValue    (regValue)
    );

    registerDecoder registerDecoder_inst (
        .i_Clock      (i_Clock),
        .i_rstN       (i_rstN),
        .i_WriteLevel (writeLevel),
        .i_RegNumber  (regNumber),
        .i_RegValue   (regValue),
        .o_Config     (configBus_inst)
    );

    phaseAccumulator phaseAccumulator_inst (
        .i_Clock  (i_Clock),
        .i_rstN   (i_rstN),
        .i_Config (configBus_inst),
        .o_Slot   (accSlot),
        .o_NoteOn (accNoteOn),
        .o_Phase  (accPhase)
    );

    waveformGenerator waveformGenerator_inst (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_Config   (configBus_inst),
        .i_Slot     (accSlot),
        .i_NoteOn   (accNoteOn),
        .i_Phase    (accPhase),
        .o_Slot     (waveSlot),
        .o_NoteOn   (waveNoteOn),
        .o_Waveform (waveform)
    );

    operatorMixer operatorMixer_inst (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_Config      (configBus_inst),
        .i_Slot        (waveSlot),
        .i_NoteOn      (waveNoteOn),
        .i_Waveform    (waveform),
        .o_SampleReady (sampleReady),
        .o_Sample      (mixSample)
    );

endmodule

`default_nettype wire

//--- operatorMixer.sv
`default_nettype none
`include "synth_cfg.svh"

module operatorMixer (
    input wire logic i_Clock,
    input wire logic i_rstN,
    configBus.stage i_Config,
    input wire synthPipePkg::slotId_t i_Slot,
    input wire logic i_NoteOn,
    input wire synthPipePkg::sample_t i_Waveform,
    output logic o_SampleReady,
    output synthPipePkg::sample_t o_Sample
);

    localparam int LevelBits = $bits(synthPipePkg::level_t);
    localparam int ProductBits = $bits(synthPipePkg::sample_t) + LevelBits + 1;
    localparam int SumBits = ProductBits + $clog2(`SYNTH_NUM_SLOTS);
    localparam logic signed [SumBits-1:0] SampleMax = 32767;
    localparam logic signed [SumBits-1:0] SampleMin = -32768;
    localparam synthPipePkg::slotId_t LastSlot = synthPipePkg::slotId_t'(`SYNTH_NUM_SLOTS - 1);

    synthPipePkg::level_t levels [`SYNTH_NUM_SLOTS];
    logic signed [ProductBits-1:0] product;
    logic signed [SumBits-1:0] term;
    logic signed [SumBits-1:0] total;
    logic signed [SumBits-1:0] accum;
    synthPipePkg::sample_t saturated;

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < `SYNTH_NUM_SLOTS; i++) begin
                levels[i] <= '0;
            end
        end else if (i_Config.levelWrite) begin
            levels[i_Config.slot] <= synthPipePkg::level_t'(i_Config.data);
        end
    end

    // Each active operator is scaled and shifted on its own before the sum
    assign product = i_Waveform * $signed({1'b0, levels[i_Slot]});

    always_comb begin
        term = '0;
        if (i_NoteOn) begin
            term = product >>> LevelBits;
        end
        total = (i_Slot == '0) ? term : accum + term;
        if (total > SampleMax) begin
            saturated = 16'h7FFF;
        end else if (total < SampleMin) begin
            saturated = 16'h8000;
        end else begin
            saturated = total[15:0];
        end
    end

    // Running sum restarts at slot 0
    always_ff @(posedge i_Clock) begin
        accum <= total;
    end

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_SampleReady <= 1'b0;
            o_Sample <= '0;
        end else begin
            o_SampleReady <= (i_Slot == LastSlot);
            if (i_Slot == LastSlot) begin
                o_Sample <= saturated;
            end
        end
    end

    assert property (@(posedge i_Clock) disable iff (!i_rstN) o_SampleReady |=> !o_SampleReady);

endmodule

`default_nettype wire

//--- phaseAccumulator.sv
`default_nettype none
`include "synth_cfg.svh"

module phaseAccumulator (
    input wire logic i_Clock,
    input wire logic i_rstN,
    configBus.stage i_Config,
    output synthPipePkg::slotId_t o_Slot,
    output logic o_NoteOn,
    output synthPipePkg::phase_t o_Phase
);

    synthPipePkg::slotId_t slotCounter;
    synthPipePkg::phase_t phaseStep [`SYNTH_NUM_SLOTS];
    synthPipePkg::phase_t phase [`SYNTH_NUM_SLOTS];
    logic [`SYNTH_NUM_SLOTS-1:0] noteOn;

    // Round robin over all slots, one per clock
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            slotCounter <= '0;
        end else if (slotCounter == synthPipePkg::slotId_t'(`SYNTH_NUM_SLOTS - 1)) begin
            slotCounter <= '0;
        end else begin
            slotCounter <= slotCounter + 1'b1;
        end
    end

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < `SYNTH_NUM_SLOTS; i++) begin
                phaseStep[i] <= '0;
            end
        end else if (i_Config.phaseStepWrite) begin
            phaseStep[i_Config.slot] <= i_Config.data;
        end
    end

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < `SYNTH_NUM_SLOTS; i++) begin
                phase[i] <= '0;
            end
            noteOn <= '0;
            o_Slot <= '0;
            o_NoteOn <= 1'b0;
            o_Phase <= '0;
        end else begin
            o_Slot <= slotCounter;
            o_NoteOn <= noteOn[slotCounter];
            o_Phase <= phase[slotCounter];
            if (noteOn[slotCounter]) begin
                phase[slotCounter] <= phase[slotCounter] + phaseStep[slotCounter];
            end
            // Note off parks the phase at zero, overriding the add above
            if (i_Config.noteOnWrite) begin
                noteOn[i_Config.slot] <= i_Config.data[0];
                if (!i_Config.data[0]) begin
                    phase[i_Config.slot] <= '0;
                end
            end
        end
    end

    assert property (@(posedge i_Clock) disable iff (!i_rstN) slotCounter < `SYNTH_NUM_SLOTS);

endmodule

`default_nettype wire

//--- registerDecoder.sv
`default_nettype none
`include "synth_cfg.svh"

module registerDecoder (
    input wire logic i_Clock,
    input wire logic i_rstN,
    input wire logic i_WriteLevel,
    input wire synthRegPkg::regNumber_u i_RegNumber,
    input wire synthRegPkg::regValue_t i_RegValue,
    configBus.decoder o_Config
);

    logic levelLast;
    logic writePulse;
    logic voiceOpHit;
    logic globalHit;

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            levelLast <= 1'b0;
        end else begin
            levelLast <= i_WriteLevel;
        end
    end

    // One write per frame
    assign writePulse = i_WriteLevel && !levelLast;

    // Out of range voices, operators and table entries are dropped
    assign voiceOpHit = writePulse
        && i_RegNumber.voiceOp.prefix == synthRegPkg::PrefixVoiceOp
        && i_RegNumber.voiceOp.voice < `SYNTH_NUM_VOICES
        && i_RegNumber.voiceOp.op < `SYNTH_NUM_OPERATORS;
    assign globalHit = writePulse
        && i_RegNumber.globalReg.prefix == synthRegPkg::PrefixGlobal
        && i_RegNumber.globalReg.tableAddr < `SYNTH_TABLE_DEPTH;

    assign o_Config.phaseStepWrite = voiceOpHit
        && i_RegNumber.voiceOp.param == synthRegPkg::PhaseStep;
    assign o_Config.levelWrite = voiceOpHit && i_RegNumber.voiceOp.param == synthRegPkg::Level;
    assign o_Config.noteOnWrite = voiceOpHit && i_RegNumber.voiceOp.param == synthRegPkg::NoteOn;
    assign o_Config.tableWrite = globalHit;

    assign o_Config.slot = synthPipePkg::slotId_t'(
        i_RegNumber.voiceOp.voice * `SYNTH_NUM_OPERATORS + i_RegNumber.voiceOp.op);
    assign o_Config.tableAddr = synthPipePkg::tableAddr_t'(i_RegNumber.globalReg.tableAddr);
    assign o_Config.data = i_RegValue;

    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        $onehot0({o_Config.phaseStepWrite, o_Config.levelWrite,
                  o_Config.noteOnWrite, o_Config.tableWrite}));

endmodule

`default_nettype wire

//--- spiSlave.sv
`default_nettype none
`include "synth_cfg.svh"

module spiSlave (
    input wire logic i_Clock,
    input wire logic i_rstN,
    input wire logic i_SpiCs,
    input wire logic i_SpiSck,
    input wire logic i_SpiMosi,
    output logic o_SpiMiso,
    input wire logic i_SampleReady,
    input wire synthPipePkg::sample_t i_Sample,
    output logic o_WriteLevel,
    output synthRegPkg::regNumber_u o_RegNumber,
    output synthRegPkg::regValue_t o_RegValue
);

    localparam int CountBits = $clog2(`SYNTH_FRAME_BITS + 1);

    logic [1:0] csSync;
    logic [1:0] sckSync;
    logic [1:0] mosiSync;
    logic csLast;
    logic sckLast;
    logic csActive;
    logic csFall;
    logic sckRise;
    logic sckFall;
    logic frameBit;
    logic [CountBits-1:0] bitCount;
    logic [`SYNTH_FRAME_BITS-1:0] frameShift;
    synthPipePkg::sample_t heldSample;
    logic [15:0] misoShift;

    // Two flops on every pin, a third for edge detection
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            csSync <= 2'b11;
            sckSync <= 2'b00;
            mosiSync <= 2'b00;
            csLast <= 1'b1;
            sckLast <= 1'b0;
        end else begin
            csSync <= {csSync[0], i_SpiCs};
            sckSync <= {sckSync[0], i_SpiSck};
            mosiSync <= {mosiSync[0], i_SpiMosi};
            csLast <= csSync[1];
            sckLast <= sckSync[1];
        end
    end

    assign csActive = !csSync[1];
    assign csFall = !csSync[1] && csLast;
    assign sckRise = sckSync[1] && !sckLast;
    assign sckFall = !sckSync[1] && sckLast;
    assign frameBit = csActive && sckRise && (bitCount < CountBits'(`SYNTH_FRAME_BITS));

    // Level rises on the last bit and holds until CS goes high
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            bitCount <= '0;
            o_WriteLevel <= 1'b0;
        end else if (!csActive) begin
            bitCount <= '0;
            o_WriteLevel <= 1'b0;
        end else if (frameBit) begin
            bitCount <= bitCount + 1'b1;
            if (bitCount == CountBits'(`SYNTH_FRAME_BITS - 1)) begin
                o_WriteLevel <= 1'b1;
            end
        end
    end

    // MSB first, register number ends up in the upper half
    always_ff @(posedge i_Clock) begin
        if (frameBit) begin
            frameShift <= {frameShift[`SYNTH_FRAME_BITS-2:0], mosiSync[1]};
        end
    end

    assign o_RegNumber = frameShift[`SYNTH_FRAME_BITS-1 -: 16];
    assign o_RegValue = frameShift[15:0];

    // Sample readout, loaded at frame start and shifted after each falling SCK
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            heldSample <= '0;
            misoShift <= '0;
        end else begin
            if (i_SampleReady) begin
                heldSample <= i_Sample;
            end
            if (csFall) begin
                misoShift <= heldSample;
            end else if (csActive && sckFall) begin
                misoShift <= {misoShift[14:0], 1'b0};
            end
        end
    end

    assign o_SpiMiso = misoShift[15];

    assert property (@(posedge i_Clock) disable iff (!i_rstN) csLast |-> !o_WriteLevel);

endmodule

`default_nettype wire

//--- synthPipePkg.sv
`default_nettype none
`include "synth_cfg.svh"

package synthPipePkg;

    // Slot number is voice * operators + operator
    typedef logic [$clog2(`SYNTH_NUM_SLOTS)-1:0] slotId_t;
    typedef logic [15:0] phase_t;
    typedef logic signed [15:0] sample_t;
    typedef logic [7:0] level_t;
    typedef logic [$clog2(`SYNTH_TABLE_DEPTH)-1:0] tableAddr_t;

endpackage

`default_nettype wire

//--- synthRegPkg.sv
`default_nettype none

package synthRegPkg;

    // Top two bits of a register number pick the view
    localparam logic [1:0] PrefixVoiceOp = 2'b11;
    localparam logic [1:0] PrefixGlobal = 2'b10;

    typedef enum logic [5:0] {
        PhaseStep = 6'h00,
        Level = 6'h02,
        NoteOn = 6'h10
    } param_e;

    // 11 PPPPPP VVVVV OOO
    typedef struct packed {
        logic [1:0] prefix;
        logic [5:0] param;
        logic [4:0] voice;
        logic [2:0] op;
    } voiceOpReg_t;

    // 10 AAAAAAAAAAAAAA, sine table address
    typedef struct packed {
        logic [1:0] prefix;
        logic [13:0] tableAddr;
    } globalReg_t;

    typedef union packed {
        voiceOpReg_t voiceOp;
        globalReg_t globalReg;
    } regNumber_u;

    typedef logic [15:0] regValue_t;

endpackage

`default_nettype wire

//--- synth_cfg.svh
`ifndef SYNTH_CFG_SVH
`define SYNTH_CFG_SVH

// Voice and operator layout
`define SYNTH_NUM_VOICES 4
`define SYNTH_NUM_OPERATORS 2
`define SYNTH_NUM_SLOTS (`SYNTH_NUM_VOICES * `SYNTH_NUM_OPERATORS)

// Sine table entries, indexed by the top phase bits
`define SYNTH_TABLE_DEPTH 256

// Register number followed by register value
`define SYNTH_FRAME_BITS 32

`endif

//--- tb_fmSynth.sv
`default_nettype none

module tb_fmSynth;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SckHalf = 5;
    localparam int ReadWait = 40;
    localparam int FrameClocks = 2 * SckHalf * 32 + 3 * SckHalf;
    // About 1080 frames over all tests, a quarter on top as margin
    localparam int MaxFrames = 1100;
    localparam int TimeoutCycles = MaxFrames * FrameClocks * 5 / 4;

    localparam logic [5:0] ParamPhaseStep = 6'h00;
    localparam logic [5:0] ParamLevel = 6'h02;
    localparam logic [5:0] ParamNoteOn = 6'h10;

    logic clock;
    logic rstN;
    logic spiCs;
    logic spiSck;
    logic spiMosi;
    wire logic spiMiso;

    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testErrors = 0;
    int testCount = 0;

    fmSynth fmSynth_inst (
        .i_Clock   (clock),
        .i_rstN    (rstN),
        .i_SpiCs   (spiCs),
        .i_SpiSck  (spiSck),
        .i_SpiMosi (spiMosi),
        .o_SpiMiso (spiMiso)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run timed out after %0d cycles without reaching the end", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    // 11 PPPPPP VVVVV OOO
    function automatic logic [15:0] voiceOpAddress(input logic [5:0] param, input int voice,
                                                   input int op);
        return {2'b11, param, 5'(voice), 3'(op)};
    endfunction

    // 10 AAAAAAAAAAAAAA
    function automatic logic [15:0] tableAddress(input int addr);
        return {2'b10, 14'(addr)};
    endfunction

    // Mode 0 frame, MISO captured on the first 16 rising SCK edges
    task automatic sendFrame(input logic [15:0] regNum, input logic [15:0] regVal,
                             output logic [15:0] misoBits);
        logic [31:0] frame;
        frame = {regNum, regVal};
        misoBits = '0;
        @(posedge clock);
        spiCs <= 1'b0;
        spiMosi <= frame[31];
        for (int i = 31; i >= 0; i--) begin
            repeat (SckHalf) @(posedge clock);
            if (i >= 16) begin
                misoBits = {misoBits[14:0], spiMiso};
            end
            spiSck <= 1'b1;
            repeat (SckHalf) @(posedge clock);
            spiSck <= 1'b0;
            if (i > 0) begin
                spiMosi <= frame[i-1];
            end
        end
        repeat (SckHalf) @(posedge clock);
        spiCs <= 1'b1;
        repeat (SckHalf) @(posedge clock);
    endtask

    task automatic writeReg(input logic [15:0] regNum, input int value);
        logic [15:0] unused;
        sendFrame(regNum, 16'(value), unused);
    endtask

    task automatic writeSlot(input logic [5:0] param, input int slot, input int value);
        writeReg(voiceOpAddress(param, slot / 2, slot % 2), value);
    endtask

    task automatic fillTable(input int value);
        for (int a = 0; a < 256; a++) begin
            writeReg(tableAddress(a), value);
        end
    endtask

    // Frame to an unused global address, only the sample readout matters
    task automatic readSample(output int value);
        logic signed [15:0] bits;
        repeat (ReadWait) @(posedge clock);
        sendFrame(tableAddress(14'h3FFF), 16'h0000, bits);
        value = bits;
    endtask

    task automatic checkValue(input string testName, input int expected, input int actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("error %s expected %0d actual %0d", testName, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string testName);
        testCount++;
        $display("test %s %s", testName, (testErrors == 0) ? "ok" : "failed");
        testErrors = 0;
    endtask

    initial begin
        int k;
        int l;
        int l2;
        int a;
        int b;
        int actual;
        rstN = 1'b0;
        spiCs = 1'b1;
        spiSck = 1'b0;
        spiMosi = 1'b0;
        void'($urandom(89376));
        repeat (3) @(posedge clock);
        rstN <= 1'b1;
        repeat (2) @(posedge clock);

        readSample(actual);
        checkValue("reset", 0, actual);
        readSample(actual);
        checkValue("reset", 0, actual);
        finishTest("reset");

        // Constant table makes the phase step irrelevant
        k = int'($urandom_range(32000)) - 16000;
        l = int'($urandom_range(255, 1));
        fillTable(k);
        writeSlot(ParamLevel, 3, l);
        writeSlot(ParamPhaseStep, 3, int'($urandom_range(16'hFFFF)));
        writeSlot(ParamNoteOn, 3, 1);
        readSample(actual);
        checkValue("one_operator", (k * l) >>> 8, actual);
        finishTest("one_operator");

        l2 = int'($urandom_range(255, 1));
        writeSlot(ParamLevel, 6, l2);
        writeSlot(ParamPhaseStep, 6, int'($urandom_range(16'hFFFF)));
        writeSlot(ParamNoteOn, 6, 1);
        readSample(actual);
        checkValue("two_operators", ((k * l) >>> 8) + ((k * l2) >>> 8), actual);
        fillTable(32000);
        for (int s = 0; s < 8; s++) begin
            writeSlot(ParamLevel, s, 255);
            writeSlot(ParamNoteOn, s, 1);
        end
        readSample(actual);
        checkValue("two_operators_saturation", 32767, actual);
        finishTest("two_operators");

        for (int s = 0; s < 8; s++) begin
            writeSlot(ParamNoteOn, s, 0);
        end
        readSample(actual);
        checkValue("note_off", 0, actual);
        finishTest("note_off");

        k = int'($urandom_range(32000)) - 16000;
        l = int'($urandom_range(255, 1));
        fillTable(k);
        writeSlot(ParamLevel, 3, l);
        // Slot 3 parks on entry 0, where table address 256 would wrap to
        writeSlot(ParamPhaseStep, 3, 0);
        writeSlot(ParamNoteOn, 3, 1);
        // Truncated decodes would land on slots 3, 2 and 4 and table entries 44 and 0
        writeReg(voiceOpAddress(ParamLevel, 5, 1), 255);
        writeReg(voiceOpAddress(ParamNoteOn, 5, 0), 1);
        writeReg(voiceOpAddress(ParamNoteOn, 0, 4), 1);
        writeReg(voiceOpAddress(6'h07, 1, 1), 0);
        writeReg(tableAddress(300), k ^ 16'h7FFF);
        writeReg(tableAddress(256), k ^ 16'h7FFF);
        readSample(actual);
        checkValue("ignored_writes", (k * l) >>> 8, actual);
        finishTest("ignored_writes");

        a = int'($urandom_range(32000)) - 16000;
        b = int'($urandom_range(32000)) - 16000;
        writeSlot(ParamNoteOn, 3, 0);
        fillTable(b);
        writeReg(tableAddress(0), a);
        writeSlot(ParamPhaseStep, 0, 0);
        writeSlot(ParamLevel, 0, 255);
        writeSlot(ParamNoteOn, 0, 1);
        readSample(actual);
        checkValue("phase_step_zero", (a * 255) >>> 8, actual);
        finishTest("phase_step_zero");

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- waveformGenerator.sv
`default_nettype none
`include "synth_cfg.svh"

module waveformGenerator (
    input wire logic i_Clock,
    input wire logic i_rstN,
    configBus.stage i_Config,
    input wire synthPipePkg::slotId_t i_Slot,
    input wire logic i_NoteOn,
    input wire synthPipePkg::phase_t i_Phase,
    output synthPipePkg::slotId_t o_Slot,
    output logic o_NoteOn,
    output synthPipePkg::sample_t o_Waveform
);

    synthPipePkg::sample_t sineTable [`SYNTH_TABLE_DEPTH];
    synthPipePkg::tableAddr_t readAddr;

    // Top phase bits select the entry
    assign readAddr = i_Phase[$bits(synthPipePkg::phase_t)-1 -: $bits(synthPipePkg::tableAddr_t)];

    // Table is loaded over SPI, contents undefined until written
    always_ff @(posedge i_Clock) begin
        if (i_Config.tableWrite) begin
            sineTable[i_Config.tableAddr] <= synthPipePkg::sample_t'(i_Config.data);
        end
        o_Waveform <= sineTable[readAddr];
    end

    // Slot tag travels alongside the lookup
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_Slot <= '0;
            o_NoteOn <= 1'b0;
        end else begin
            o_Slot <= i_Slot;
            o_NoteOn <= i_NoteOn;
        end
    end

endmodule

`default_nettype wire
